// File: Bender.yml
package:
  name: grid_pruner

sources:
  - common/grid_pkg.sv
  - common/bank_pkg.sv
  - grid_bank/grid_bank.sv
  - prune_engine/prune_engine.sv
  - logic/pass_controller.sv
  - logic/grid_pruner.sv
  - target: test
    files:
      - test/grid_pruner_tb.sv

// File: common/bank_pkg.sv
package bank_pkg;

    localparam int WORD_W  = 8;
    localparam int CHUNKS  = 4;
    localparam int DEPTH   = 64;
    localparam int ADDR_W  = 6;
    localparam int CHUNK_W = 2;

    // address is row times CHUNKS plus chunk
    // chunk 0 holds columns 0 to 7
    function automatic logic [ADDR_W-1:0] chunk_addr(
        input logic [ADDR_W-CHUNK_W-1:0] row,
        input logic [CHUNK_W-1:0]        chunk
    );
        return {row, chunk};
    endfunction

endpackage

// File: common/grid_pkg.sv
package grid_pkg;

    // grid geometry
    localparam int GRID_COLS = 32;
    localparam int GRID_ROWS = 16;
    localparam int ROW_W     = 4;
    localparam int COL_W     = 5;

    // a set cell with fewer set neighbours than this is cleared
    localparam int PRUNE_LIMIT = 4;

    // pass limits and counter widths
    localparam int MAX_PASSES = 8;
    localparam int PASS_W     = 4;
    localparam int COUNT_W    = 10;

    // prune engine FSM encoding
    localparam int ENG_STATE_W = 3;
    localparam logic [ENG_STATE_W-1:0] ENG_IDLE     = 3'd0;
    localparam logic [ENG_STATE_W-1:0] ENG_LOAD_REQ = 3'd1;
    localparam logic [ENG_STATE_W-1:0] ENG_LOAD_ACK = 3'd2;
    localparam logic [ENG_STATE_W-1:0] ENG_SHIFT    = 3'd3;
    localparam logic [ENG_STATE_W-1:0] ENG_WRITE    = 3'd4;

endpackage

// File: grid_bank/grid_bank.sv
`timescale 1ns/1ps

module grid_bank (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        busy_i,
    input  logic                        host_we_i,
    input  logic                        host_re_i,
    input  logic [bank_pkg::ADDR_W-1:0] host_addr_i,
    input  logic [bank_pkg::WORD_W-1:0] host_wdata_i,
    input  logic                        eng_we_i,
    input  logic                        eng_re_i,
    input  logic [bank_pkg::ADDR_W-1:0] eng_addr_i,
    input  logic [bank_pkg::WORD_W-1:0] eng_wdata_i,
    output logic [bank_pkg::WORD_W-1:0] rdata_o,
    output logic                        ack_o
);

    logic [bank_pkg::WORD_W-1:0] mem [bank_pkg::DEPTH];

    logic                        we;
    logic                        re;
    logic [bank_pkg::ADDR_W-1:0] addr;
    logic [bank_pkg::WORD_W-1:0] wdata;

    // engine owns the single port while a run is in progress
    assign we    = busy_i ? eng_we_i    : host_we_i;
    assign re    = busy_i ? eng_re_i    : host_re_i;
    assign addr  = busy_i ? eng_addr_i  : host_addr_i;
    assign wdata = busy_i ? eng_wdata_i : host_wdata_i;

    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        if (re) begin
            rdata_o <= mem[addr];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= busy_i && eng_re_i;
        end
    end

    // host stays off the bank while the engine runs
    a_no_host_when_busy : assert property (
        @(posedge clock) disable iff (reset)
        busy_i |-> !(host_we_i || host_re_i)
    ) else $error("host access while busy");

    a_no_eng_rw : assert property (
        @(posedge clock) disable iff (reset)
        !(eng_re_i && eng_we_i)
    ) else $error("engine read and write in one cycle");

    // engine requests only make sense while it owns the port
    a_eng_only_when_busy : assert property (
        @(posedge clock) disable iff (reset)
        (eng_re_i || eng_we_i) |-> busy_i
    ) else $error("engine access while idle");

endmodule

// File: grid_pruner.f
common/grid_pkg.sv
common/bank_pkg.sv
grid_bank/grid_bank.sv
prune_engine/prune_engine.sv
logic/pass_controller.sv
logic/grid_pruner.sv
test/grid_pruner_tb.sv

// File: logic/grid_pruner.sv
`timescale 1ns/1ps

module grid_pruner (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start_i,
    input  logic                         host_we_i,
    input  logic                         host_re_i,
    input  logic [bank_pkg::ADDR_W-1:0]  host_addr_i,
    input  logic [bank_pkg::WORD_W-1:0]  host_wdata_i,
    output logic [bank_pkg::WORD_W-1:0]  host_rdata_o,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [grid_pkg::PASS_W-1:0]  passes_o,
    output logic [grid_pkg::COUNT_W-1:0] pruned_o
);

    logic                        run;
    logic                        pass_done;
    logic                        prune_pulse;
    logic                        eng_re;
    logic                        eng_we;
    logic [bank_pkg::ADDR_W-1:0] eng_addr;
    logic [bank_pkg::WORD_W-1:0] eng_wdata;
    logic [bank_pkg::WORD_W-1:0] rdata;
    logic                        ack;

    // one read data path serves host and engine
    assign host_rdata_o = rdata;

    pass_controller u_ctrl (
        .clock       (clock),
        .reset       (reset),
        .start_i     (start_i),
        .pass_done_i (pass_done),
        .prune_i     (prune_pulse),
        .run_o       (run),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .passes_o    (passes_o),
        .pruned_o    (pruned_o)
    );

    grid_bank u_bank (
        .clock        (clock),
        .reset        (reset),
        .busy_i       (busy_o),
        .host_we_i    (host_we_i),
        .host_re_i    (host_re_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .eng_we_i     (eng_we),
        .eng_re_i     (eng_re),
        .eng_addr_i   (eng_addr),
        .eng_wdata_i  (eng_wdata),
        .rdata_o      (rdata),
        .ack_o        (ack)
    );

    prune_engine u_engine (
        .clock      (clock),
        .reset      (reset),
        .run_i      (run),
        .ack_i      (ack),
        .rdata_i    (rdata),
        .read_en_o  (eng_re),
        .write_en_o (eng_we),
        .addr_o     (eng_addr),
        .wdata_o    (eng_wdata),
        .prune_o    (prune_pulse),
        .done_o     (pass_done)
    );

endmodule

// File: logic/pass_controller.sv
`timescale 1ns/1ps

module pass_controller (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start_i,
    input  logic                         pass_done_i,
    input  logic                         prune_i,
    output logic                         run_o,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [grid_pkg::PASS_W-1:0]  passes_o,
    output logic [grid_pkg::COUNT_W-1:0] pruned_o
);

    // set once the current pass clears a cell
    logic changed;
    logic again;

    // another pass only if this one changed something and the cap allows it
    assign again = (changed || prune_i)
                && (passes_o < grid_pkg::PASS_W'(grid_pkg::MAX_PASSES - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            run_o    <= 1'b0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            passes_o <= '0;
            pruned_o <= '0;
            changed  <= 1'b0;
        end else begin
            run_o  <= 1'b0;
            done_o <= 1'b0;
            if (!busy_o) begin
                if (start_i) begin
                    busy_o   <= 1'b1;
                    run_o    <= 1'b1;
                    passes_o <= '0;
                    pruned_o <= '0;
                    changed  <= 1'b0;
                end
            end else begin
                if (prune_i) begin
                    pruned_o <= pruned_o + 1'b1;
                end
                if (pass_done_i) begin
                    passes_o <= passes_o + 1'b1;
                    changed  <= 1'b0;
                    if (again) begin
                        run_o <= 1'b1;
                    end else begin
                        done_o <= 1'b1;
                        busy_o <= 1'b0;
                    end
                end else if (prune_i) begin
                    changed <= 1'b1;
                end
            end
        end
    end

endmodule

// File: prune_engine/prune_engine.sv
`timescale 1ns/1ps

module prune_engine (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        run_i,
    input  logic                        ack_i,
    input  logic [bank_pkg::WORD_W-1:0] rdata_i,
    output logic                        read_en_o,
    output logic                        write_en_o,
    output logic [bank_pkg::ADDR_W-1:0] addr_o,
    output logic [bank_pkg::WORD_W-1:0] wdata_o,
    output logic                        prune_o,
    output logic                        done_o
);

    logic [grid_pkg::ENG_STATE_W-1:0] state;

    // three window rows with win1 the row being pruned
    logic [grid_pkg::GRID_COLS-1:0] win0;
    logic [grid_pkg::GRID_COLS-1:0] win1;
    logic [grid_pkg::GRID_COLS-1:0] win2;
    logic [grid_pkg::GRID_COLS-1:0] next0;
    logic [grid_pkg::GRID_COLS-1:0] next1;
    logic [grid_pkg::GRID_COLS-1:0] next2;

    logic [grid_pkg::ROW_W-1:0]   row;
    logic [grid_pkg::ROW_W:0]     load_row;
    logic [grid_pkg::COL_W-1:0]   col;
    logic [bank_pkg::CHUNK_W-1:0] chunk;
    logic                         load_sel;

    logic                        past_last;
    logic                        first_col;
    logic                        last_col;
    logic [7:0]                  nb;
    logic [3:0]                  nb_sum;
    logic                        prune;
    logic [bank_pkg::WORD_W-1:0] chunk_data;

    assign first_col = (col == '0);
    assign last_col  = (col == grid_pkg::COL_W'(grid_pkg::GRID_COLS - 1));
    assign past_last = (load_row == (grid_pkg::ROW_W + 1)'(grid_pkg::GRID_ROWS));

    // bit 0 is the centre column, bit 1 the right and the top bit the left neighbour
    always_comb begin
        nb = {win0[grid_pkg::GRID_COLS-1] && !first_col, win0[0], win0[1] && !last_col,
              win1[grid_pkg::GRID_COLS-1] && !first_col,          win1[1] && !last_col,
              win2[grid_pkg::GRID_COLS-1] && !first_col, win2[0], win2[1] && !last_col};
        nb_sum = '0;
        for (int i = 0; i < 8; i++) begin
            nb_sum = nb_sum + 4'(nb[i]);
        end
        prune = win1[0] && (nb_sum < 4'(grid_pkg::PRUNE_LIMIT));

        // the cleared cell becomes the left neighbour of the next one
        next0 = {win0[0], win0[grid_pkg::GRID_COLS-1:1]};
        next1 = {win1[0] && !prune, win1[grid_pkg::GRID_COLS-1:1]};
        next2 = {win2[0], win2[grid_pkg::GRID_COLS-1:1]};
    end

    // no read past the last row, so the chunk comes in as zero
    assign chunk_data = ack_i ? rdata_i : '0;

    assign read_en_o  = (state == grid_pkg::ENG_LOAD_REQ) && !past_last;
    assign write_en_o = (state == grid_pkg::ENG_WRITE);
    assign addr_o     = write_en_o ? bank_pkg::chunk_addr(row, chunk)
                                   : bank_pkg::chunk_addr(load_row[grid_pkg::ROW_W-1:0], chunk);
    assign wdata_o    = win1[chunk*bank_pkg::WORD_W +: bank_pkg::WORD_W];
    assign prune_o    = (state == grid_pkg::ENG_SHIFT) && prune;

    // control
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= grid_pkg::ENG_IDLE;
            row      <= '0;
            load_row <= '0;
            col      <= '0;
            chunk    <= '0;
            load_sel <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                grid_pkg::ENG_IDLE: begin
                    if (run_i) begin
                        row      <= '0;
                        load_row <= '0;
                        chunk    <= '0;
                        load_sel <= 1'b0;
                        state    <= grid_pkg::ENG_LOAD_REQ;
                    end
                end
                grid_pkg::ENG_LOAD_REQ: begin
                    state <= grid_pkg::ENG_LOAD_ACK;
                end
                grid_pkg::ENG_LOAD_ACK: begin
                    chunk <= chunk + 1'b1;
                    state <= grid_pkg::ENG_LOAD_REQ;
                    if (chunk == '1) begin
                        if (!load_sel) begin
                            // row 1 follows the first row of the initial load
                            load_sel <= 1'b1;
                            load_row <= load_row + 1'b1;
                        end else begin
                            col   <= '0;
                            state <= grid_pkg::ENG_SHIFT;
                        end
                    end
                end
                grid_pkg::ENG_SHIFT: begin
                    col <= col + 1'b1;
                    if (last_col) begin
                        state <= grid_pkg::ENG_WRITE;
                    end
                end
                grid_pkg::ENG_WRITE: begin
                    chunk <= chunk + 1'b1;
                    if (chunk == '1) begin
                        if (row == grid_pkg::ROW_W'(grid_pkg::GRID_ROWS - 1)) begin
                            done_o <= 1'b1;
                            state  <= grid_pkg::ENG_IDLE;
                        end else begin
                            row      <= row + 1'b1;
                            load_row <= load_row + 1'b1;
                            state    <= grid_pkg::ENG_LOAD_REQ;
                        end
                    end
                end
                default: begin
                    state <= grid_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    // window datapath
    always_ff @(posedge clock) begin
        case (state)
            grid_pkg::ENG_IDLE: begin
                if (run_i) begin
                    win0 <= '0;
                end
            end
            grid_pkg::ENG_LOAD_ACK: begin
                if (load_sel) begin
                    win2[chunk*bank_pkg::WORD_W +: bank_pkg::WORD_W] <= chunk_data;
                end else begin
                    win1[chunk*bank_pkg::WORD_W +: bank_pkg::WORD_W] <= chunk_data;
                end
            end
            grid_pkg::ENG_SHIFT: begin
                win0 <= next0;
                win1 <= next1;
                win2 <= next2;
            end
            grid_pkg::ENG_WRITE: begin
                // slide down once the row is out
                if (chunk == '1) begin
                    win0 <= win1;
                    win1 <= win2;
                end
            end
            default: begin
            end
        endcase
    end

    // the bank answers every read exactly one cycle later
    a_ack_after_read : assert property (
        @(posedge clock) disable iff (reset)
        read_en_o |=> ack_i
    ) else $error("read not acknowledged");

    a_ack_only_after_read : assert property (
        @(posedge clock) disable iff (reset)
        ack_i |-> $past(read_en_o)
    ) else $error("acknowledge without a read");

endmodule

// File: test/grid_pruner_tb.sv
`timescale 1ns/1ps

module grid_pruner_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int PASS_CYCLES = 16 + grid_pkg::GRID_ROWS * (grid_pkg::GRID_COLS + 4 + 8) - 8;
    // grid load and readback take two cycles per word each
    localparam int RUN_CYCLES  = grid_pkg::MAX_PASSES * PASS_CYCLES + 4 * bank_pkg::DEPTH + 200;
    localparam int NUM_RUNS    = 9;
    localparam int TIMEOUT_CYCLES = (NUM_RUNS + 1) * RUN_CYCLES + 100;

    logic                         clock;
    logic                         reset;
    logic                         start_i;
    logic                         host_we_i;
    logic                         host_re_i;
    logic [bank_pkg::ADDR_W-1:0]  host_addr_i;
    logic [bank_pkg::WORD_W-1:0]  host_wdata_i;
    logic [bank_pkg::WORD_W-1:0]  host_rdata_o;
    logic                         busy_o;
    logic                         done_o;
    logic [grid_pkg::PASS_W-1:0]  passes_o;
    logic [grid_pkg::COUNT_W-1:0] pruned_o;

    logic [grid_pkg::GRID_COLS-1:0] model_grid [grid_pkg::GRID_ROWS];
    logic [bank_pkg::WORD_W-1:0]    exp_words [bank_pkg::DEPTH];
    logic [31:0]                    rng_state;
    int                             checks;
    int                             errors;

    grid_pruner dut (
        .clock        (clock),
        .reset        (reset),
        .start_i      (start_i),
        .host_we_i    (host_we_i),
        .host_re_i    (host_re_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .passes_o     (passes_o),
        .pruned_o     (pruned_o)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("timeout: the DUT did not finish its runs in the expected time");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // set neighbours of one cell with cells off the grid counted as zero
    function automatic int count_neighbours(input int r, input int c);
        int n;
        n = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if ((dr != 0 || dc != 0) && r + dr >= 0 && r + dr < grid_pkg::GRID_ROWS
                        && c + dc >= 0 && c + dc < grid_pkg::GRID_COLS) begin
                    if (model_grid[r + dr][c + dc]) begin
                        n++;
                    end
                end
            end
        end
        return n;
    endfunction

    // in-place sweep where a cleared cell is seen at once by later cells
    function automatic int sweep_model();
        int cleared;
        cleared = 0;
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            for (int c = 0; c < grid_pkg::GRID_COLS; c++) begin
                if (model_grid[r][c] && count_neighbours(r, c) < grid_pkg::PRUNE_LIMIT) begin
                    model_grid[r][c] = 1'b0;
                    cleared++;
                end
            end
        end
        return cleared;
    endfunction

    task automatic run_model(output int passes, output int pruned);
        int cleared;
        passes = 0;
        pruned = 0;
        do begin
            cleared = sweep_model();
            passes++;
            pruned += cleared;
        end while (cleared != 0 && passes < grid_pkg::MAX_PASSES);
    endtask

    task automatic write_word(input int addr, input logic [bank_pkg::WORD_W-1:0] data);
        @(negedge clock);
        host_we_i    = 1'b1;
        host_addr_i  = bank_pkg::ADDR_W'(addr);
        host_wdata_i = data;
        @(negedge clock);
        host_we_i = 1'b0;
    endtask

    task automatic read_word(input int addr, output logic [bank_pkg::WORD_W-1:0] data);
        @(negedge clock);
        host_re_i   = 1'b1;
        host_addr_i = bank_pkg::ADDR_W'(addr);
        @(negedge clock);
        host_re_i = 1'b0;
        data      = host_rdata_o;
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic random_grid(input int percent);
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            for (int c = 0; c < grid_pkg::GRID_COLS; c++) begin
                model_grid[r][c] = (next_random() % 100) < percent;
            end
        end
    endtask

    // full rows 0 to 3 on top of a two column band that erodes one row per pass from below
    task automatic band_grid();
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            if (r < 4) begin
                model_grid[r] = '1;
            end else begin
                model_grid[r] = '0;
                model_grid[r][10] = 1'b1;
                model_grid[r][11] = 1'b1;
            end
        end
    endtask

    task automatic run_grid(input string name, input bit restart_while_busy);
        int                          exp_passes;
        int                          exp_pruned;
        int                          addr;
        logic [bank_pkg::WORD_W-1:0] data;
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            for (int k = 0; k < bank_pkg::CHUNKS; k++) begin
                write_word(r * bank_pkg::CHUNKS + k, model_grid[r][k * bank_pkg::WORD_W +: 8]);
            end
        end
        @(negedge clock);
        start_i = 1'b1;
        @(negedge clock);
        start_i = 1'b0;
        check_value({name, " busy after start"}, busy_o, 1);
        if (restart_while_busy) begin
            repeat (50) @(negedge clock);
            check_value({name, " busy before second start"}, busy_o, 1);
            start_i = 1'b1;
            @(negedge clock);
            start_i = 1'b0;
        end
        while (!done_o) begin
            @(negedge clock);
        end
        run_model(exp_passes, exp_pruned);
        check_value({name, " passes"}, passes_o, exp_passes);
        check_value({name, " pruned"}, pruned_o, exp_pruned);
        check_value({name, " busy at done"}, busy_o, 0);
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            for (int k = 0; k < bank_pkg::CHUNKS; k++) begin
                addr = r * bank_pkg::CHUNKS + k;
                read_word(addr, data);
                check_value($sformatf("%s word %0d", name, addr), data,
                            model_grid[r][k * bank_pkg::WORD_W +: 8]);
            end
        end
        $display("%s: %0d passes, %0d pruned", name, exp_passes, exp_pruned);
    endtask

    initial begin
        logic [bank_pkg::WORD_W-1:0] data;
        reset        = 1'b1;
        start_i      = 1'b0;
        host_we_i    = 1'b0;
        host_re_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        rng_state    = 32'd95;
        checks       = 0;
        errors       = 0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // plain host write and read back over the whole bank
        for (int a = 0; a < bank_pkg::DEPTH; a++) begin
            exp_words[a] = next_random() & 8'hff;
            write_word(a, exp_words[a]);
        end
        for (int a = 0; a < bank_pkg::DEPTH; a++) begin
            read_word(a, data);
            check_value($sformatf("bank word %0d", a), data, exp_words[a]);
        end

        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            model_grid[r] = '0;
        end
        run_grid("empty grid", 1'b0);

        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            model_grid[r] = '1;
        end
        run_grid("full grid", 1'b0);

        band_grid();
        run_grid("band grid", 1'b0);

        for (int i = 0; i < 4; i++) begin
            random_grid(60);
            run_grid($sformatf("random grid %0d", i), 1'b0);
        end

        random_grid(75);
        run_grid("dense grid with restart", 1'b1);

        random_grid(45);
        run_grid("sparse grid", 1'b0);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
